// File: common/enoc_pkg.sv
package enoc_pkg;

  // Router geometry
  // --------------------
  localparam int PORTS = 5;          // Input count and output count

  // Port indices, shared by route calc and testbench
  localparam int PORT_CORE  = 0;     // Local core
  localparam int PORT_NORTH = 1;     // Towards larger y
  localparam int PORT_EAST  = 2;     // Towards larger x
  localparam int PORT_SOUTH = 3;     // Towards smaller y
  localparam int PORT_WEST  = 4;     // Towards smaller x

  // Field widths
  // --------------------
  localparam int COORD_W   = 2;      // One mesh coordinate, 4x4 mesh
  localparam int PAYLOAD_W = 16;     // Data carried by each packet

  // Whole packet is x_dest, y_dest, payload from msb down
  localparam int PKT_W = 2 * COORD_W + PAYLOAD_W;

  // Packet layout
  // --------------------
  // Payload sits in the low bits, so the y field starts right above it
  localparam int Y_DEST_LSB = PAYLOAD_W;            // Bits 17:16
  localparam int X_DEST_LSB = Y_DEST_LSB + COORD_W; // Bits 19:18

  // Vector types
  // --------------------
  typedef logic [COORD_W-1:0] coord_t;   // One mesh coordinate
  typedef logic [PKT_W-1:0]   packet_t;  // One complete packet

  // One bit per port, bit p belongs to port p
  // Used for requests, grants, valids and enables
  typedef logic [PORTS-1:0] port_vec_t;

endpackage

// File: hw/enoc_router.sv
`timescale 1ns/1ps

module enoc_router #(
  parameter enoc_pkg::coord_t X_LOC = '0,        // Node position, x
  parameter enoc_pkg::coord_t Y_LOC = '0,        // Node position, y
  parameter int               DEPTH = 4          // Input queue depth
) (
  input  logic                clk,
  input  logic                reset_n,

  // Upstream bus
  // --------------------
  input  enoc_pkg::packet_t   [enoc_pkg::PORTS-1:0] i_data,      // Core, N, E, S, W
  input  enoc_pkg::port_vec_t                       i_data_val,  // Packet offered
  output enoc_pkg::port_vec_t                       o_en,        // Queue not full

  // Downstream bus
  // --------------------
  output enoc_pkg::packet_t   [enoc_pkg::PORTS-1:0] o_data,      // Core, N, E, S, W
  output enoc_pkg::port_vec_t                       o_data_val,  // Packet leaves
  input  enoc_pkg::port_vec_t                       i_en         // Downstream can accept
);

  localparam int PORTS = enoc_pkg::PORTS;

  enoc_pkg::packet_t   [PORTS-1:0] l_head_data;     // Queue heads to the switch
  enoc_pkg::port_vec_t             l_head_val;      // Queue heads valid
  enoc_pkg::port_vec_t [PORTS-1:0] l_output_req;    // Requests, by input
  enoc_pkg::port_vec_t [PORTS-1:0] l_output_grant;  // Grants, by output
  enoc_pkg::port_vec_t             l_input_pop;     // Pops, by input

  // Input channels
  // --------------------
  // Queue plus route calculator on its head, one per port
  for (genvar p = 0; p < PORTS; p++) begin : gen_input_channel
    input_fifo #(
      .DEPTH(DEPTH)
    ) input_fifo_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[p]),         // Straight from upstream
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .i_pop      (l_input_pop[p]),    // From switch control
      .o_data     (l_head_data[p]),
      .o_data_val (l_head_val[p])
    );

    route_calc #(
      .X_LOC(X_LOC),
      .Y_LOC(Y_LOC)
    ) route_calc_i (
      .i_data       (l_head_data[p]),
      .i_val        (l_head_val[p]),
      .o_output_req (l_output_req[p])
    );
  end

  // Arbitration
  // --------------------
  switch_control switch_control_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_output_req   (l_output_req),
    .i_en           (i_en),            // Blocked outputs grant nothing
    .o_output_grant (l_output_grant),
    .o_input_pop    (l_input_pop)
  );

  // Switch
  // --------------------
  output_switch output_switch_i (
    .i_sel      (l_output_grant),
    .i_data     (l_head_data),
    .o_data     (o_data),
    .o_data_val (o_data_val)
  );

endmodule

// File: hw/input_channel/input_fifo.sv
`timescale 1ns/1ps

module input_fifo #(
  parameter int DEPTH = 4                      // Queue depth, power of two, 2 or more
) (
  input  logic              clk,
  input  logic              reset_n,

  // Upstream side
  input  enoc_pkg::packet_t i_data,            // Packet from upstream node
  input  logic              i_data_val,        // Packet offered this cycle
  output logic              o_en,              // Not full, upstream may send

  // Switch side
  input  logic              i_pop,             // Head leaves through the switch
  output enoc_pkg::packet_t o_data,            // Head packet
  output logic              o_data_val         // Head holds a packet
);

  localparam int PTR_W = $clog2(DEPTH);        // Pointer wraps naturally
  localparam int CNT_W = $clog2(DEPTH + 1);    // Count must reach DEPTH

  // Storage and pointers
  // --------------------
  enoc_pkg::packet_t mem [DEPTH];              // Packet storage

  logic [PTR_W-1:0] wr_ptr;                    // Next free slot
  logic [PTR_W-1:0] rd_ptr;                    // Current head
  logic [CNT_W-1:0] count;                     // Occupancy

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // A write while full is dropped
  assign wr_en = i_data_val & ~full;
  assign rd_en = i_pop & ~empty;               // Pop on empty queue is ignored

  // Storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers and occupancy
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;

      // Write and pop together leave the count unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is read straight from storage, no output register
  assign o_data     = mem[rd_ptr];
  assign o_data_val = ~empty;

  // Flow control towards upstream, combinational from the count
  assign o_en = ~full;

endmodule

// File: hw/input_channel/route_calc.sv
`timescale 1ns/1ps

module route_calc #(
  parameter enoc_pkg::coord_t X_LOC = '0,        // This node, x position
  parameter enoc_pkg::coord_t Y_LOC = '0         // This node, y position
) (
  input  enoc_pkg::packet_t   i_data,            // Head packet of the local queue
  input  logic                i_val,             // Head is valid
  output enoc_pkg::port_vec_t o_output_req       // One-hot output request
);

  // Destination fields
  // --------------------
  enoc_pkg::coord_t x_dest;
  enoc_pkg::coord_t y_dest;

  assign x_dest = i_data[enoc_pkg::X_DEST_LSB +: enoc_pkg::COORD_W];
  assign y_dest = i_data[enoc_pkg::Y_DEST_LSB +: enoc_pkg::COORD_W];

  // XY routing
  // --------------------
  // X is resolved first, y is only looked at once the column matches
  always_comb begin
    o_output_req = '0;                           // No request without a valid head
    if (i_val) begin
      if (x_dest > X_LOC) begin
        o_output_req[enoc_pkg::PORT_EAST] = 1'b1;       // Move right
      end else if (x_dest < X_LOC) begin
        o_output_req[enoc_pkg::PORT_WEST] = 1'b1;       // Move left
      end else if (y_dest > Y_LOC) begin
        o_output_req[enoc_pkg::PORT_NORTH] = 1'b1;      // Same column, move up
      end else if (y_dest < Y_LOC) begin
        o_output_req[enoc_pkg::PORT_SOUTH] = 1'b1;      // Same column, move down
      end else begin
        o_output_req[enoc_pkg::PORT_CORE] = 1'b1;       // Arrived, deliver locally
      end
    end
  end

endmodule

// File: hw/switch/output_switch.sv
`timescale 1ns/1ps

module output_switch (
  // One-hot select per output, bit i picks input i
  input  enoc_pkg::port_vec_t [enoc_pkg::PORTS-1:0] i_sel,

  input  enoc_pkg::packet_t   [enoc_pkg::PORTS-1:0] i_data,     // Queue heads, by input
  output enoc_pkg::packet_t   [enoc_pkg::PORTS-1:0] o_data,     // Switched data, by output
  output enoc_pkg::port_vec_t                       o_data_val  // Output carries a packet
);

  localparam int PORTS = enoc_pkg::PORTS;

  // Crossbar
  // --------------------
  // AND-OR mux, valid because each select is one-hot or zero
  always_comb begin
    for (int o = 0; o < PORTS; o++) begin
      o_data[o] = '0;                            // Idle output carries zero
      for (int i = 0; i < PORTS; i++) begin
        if (i_sel[o][i]) begin
          o_data[o] = o_data[o] | i_data[i];
        end
      end
    end
  end

  // Valid per output
  // --------------------
  always_comb begin
    for (int o = 0; o < PORTS; o++) begin
      o_data_val[o] = |i_sel[o];                 // Any grant means data this cycle
    end
  end

endmodule

// File: hw/switch/switch_control.sv
`timescale 1ns/1ps

module switch_control (
  input  logic                clk,
  input  logic                reset_n,

  // Requests from the route calculators, indexed by input
  input  enoc_pkg::port_vec_t [enoc_pkg::PORTS-1:0] i_output_req,

  // Downstream can accept, one bit per output
  input  enoc_pkg::port_vec_t                       i_en,

  // One-hot grants, indexed by output
  output enoc_pkg::port_vec_t [enoc_pkg::PORTS-1:0] o_output_grant,

  // Queue pops, one bit per input
  output enoc_pkg::port_vec_t                       o_input_pop
);

  localparam int PORTS = enoc_pkg::PORTS;
  localparam int PTR_W = $clog2(PORTS);          // Holds an input index

  // Requests per output
  // --------------------
  // Transposed so that each output sees one bit per input
  enoc_pkg::port_vec_t [PORTS-1:0] req_masked;

  logic [PTR_W-1:0] rr_ptr  [PORTS];             // Highest priority input per output
  logic [PTR_W-1:0] win_idx [PORTS];             // This cycle's winner per output

  always_comb begin
    for (int o = 0; o < PORTS; o++) begin
      for (int i = 0; i < PORTS; i++) begin
        // A blocked output sees no requests at all
        req_masked[o][i] = i_output_req[i][o] & i_en[o];
      end
    end
  end

  // Round-robin arbitration
  // --------------------
  // Search starts at the pointer and wraps past the last input
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    for (int o = 0; o < PORTS; o++) begin
      o_output_grant[o] = '0;
      win_idx[o]        = '0;
      found             = 1'b0;
      for (int k = 0; k < PORTS; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= PORTS) idx = idx - PORTS;       // Wrap around
        if (!found && req_masked[o][idx]) begin
          o_output_grant[o][idx] = 1'b1;          // First requester in order wins
          win_idx[o]             = PTR_W'(idx);
          found                  = 1'b1;
        end
      end
    end
  end

  // Pointer update
  // --------------------
  // The winner drops to lowest priority, the input after it goes first
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < PORTS; o++) begin
        rr_ptr[o] <= '0;                         // Input 0 first after reset
      end
    end else begin
      for (int o = 0; o < PORTS; o++) begin
        if (|o_output_grant[o]) begin
          if (win_idx[o] == PTR_W'(PORTS - 1)) begin
            rr_ptr[o] <= '0;
          end else begin
            rr_ptr[o] <= win_idx[o] + 1'b1;
          end
        end
      end
    end
  end

  // Input pops
  // --------------------
  // Each input requests one output, so at most one grant bit is set
  always_comb begin
    for (int i = 0; i < PORTS; i++) begin
      o_input_pop[i] = 1'b0;
      for (int o = 0; o < PORTS; o++) begin
        o_input_pop[i] = o_input_pop[i] | o_output_grant[o][i];
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_enoc_router \
  -f tb.f \
  -o tb_enoc_router

./obj_dir/tb_enoc_router > sim.log 2>&1
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: tb.f
common/enoc_pkg.sv
hw/input_channel/input_fifo.sv
hw/input_channel/route_calc.sv
hw/switch/switch_control.sv
hw/switch/output_switch.sv
hw/enoc_router.sv
test/tb_enoc_router.sv

// File: test/tb_enoc_router.sv
`timescale 1ns/1ps

module tb_enoc_router;

  localparam int PORTS = enoc_pkg::PORTS;
  localparam int DEPTH = 4;                      // Queue depth under test
  localparam int N_RAND = 60;                    // Random packets per input
  localparam int SRC_LSB = enoc_pkg::PAYLOAD_W - 3;  // Payload 15:13 holds the source input

  localparam enoc_pkg::coord_t X_LOC = 2'd1;     // Node under test sits at (1,2)
  localparam enoc_pkg::coord_t Y_LOC = 2'd2;

  // Latency, back-pressure, fairness, then random traffic
  localparam int TOTAL_PKTS  = PORTS + DEPTH + 2 * DEPTH + PORTS * N_RAND;
  localparam int CYCLE_LIMIT = TOTAL_PKTS * 20 + 200;

  // A full router loses at least one packet per open cycle
  localparam int DRAIN_CYCLES = 2 * PORTS * DEPTH;

  logic                                     clk;
  logic                                     reset_n;
  enoc_pkg::packet_t   [PORTS-1:0]          i_data;
  enoc_pkg::port_vec_t                      i_data_val;
  enoc_pkg::port_vec_t                      o_en;
  enoc_pkg::packet_t   [PORTS-1:0]          o_data;
  enoc_pkg::port_vec_t                      o_data_val;
  enoc_pkg::port_vec_t                      i_en;

  // Scoreboard with one queue per input and output pair
  // --------------------
  enoc_pkg::packet_t   sb_q [PORTS*PORTS][$];    // Index is src * PORTS + out
  logic [12:0]         seq [PORTS];              // Sequence number per input
  enoc_pkg::port_vec_t seen_val;                 // Last sampled outputs
  enoc_pkg::packet_t   [PORTS-1:0] seen_data;
  int                  arrive_edge [PORTS];      // Edge of the last transfer per output

  int          cyc = 0;                          // Rising edges so far
  int          n_sent = 0;
  int          n_received = 0;
  int          n_value_err = 0;
  int          n_other_err = 0;
  logic [31:0] rng_state = 32'd51820;

  enoc_router #(
    .X_LOC(X_LOC),
    .Y_LOC(Y_LOC),
    .DEPTH(DEPTH)
  ) enoc_router_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                       // 4 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Downstream never sees a packet it did not enable
  no_valid_while_blocked: assert property (
    @(posedge clk) disable iff (!reset_n) (o_data_val & ~i_en) == '0
  ) else begin
    $display("an output was valid while its downstream enable was low");
    n_other_err++;
  end

  // Helpers
  // --------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Dimension order lets x decide first and y only in the own column
  function automatic int expected_port(input int x, input int y);
    int dx;
    int dy;
    dx = x - int'(X_LOC);
    dy = y - int'(Y_LOC);
    if (dx > 0) return enoc_pkg::PORT_EAST;
    if (dx < 0) return enoc_pkg::PORT_WEST;
    if (dy > 0) return enoc_pkg::PORT_NORTH;
    if (dy < 0) return enoc_pkg::PORT_SOUTH;
    return enoc_pkg::PORT_CORE;
  endfunction

  // Some destination {x, y} that leaves through the given port
  function automatic logic [3:0] coords_for(input int port);
    case (port)
      enoc_pkg::PORT_NORTH: return {2'd1, 2'd3};
      enoc_pkg::PORT_EAST:  return {2'd2, 2'd1};
      enoc_pkg::PORT_SOUTH: return {2'd1, 2'd0};
      enoc_pkg::PORT_WEST:  return {2'd0, 2'd3};
      default:              return {2'd1, 2'd2};   // Core
    endcase
  endfunction

  function automatic int pending_packets();
    int n;
    n = 0;
    for (int k = 0; k < PORTS * PORTS; k++) n += sb_q[k].size();
    return n;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      n_value_err++;
    end
  endtask

  // Upstream offer after the caller has seen o_en high
  task automatic offer(input int src, input enoc_pkg::coord_t x, input enoc_pkg::coord_t y);
    enoc_pkg::packet_t pkt;
    pkt = {x, y, 3'(src), seq[src]};
    seq[src] = seq[src] + 13'd1;
    i_data[src]     = pkt;
    i_data_val[src] = 1'b1;
    sb_q[src * PORTS + expected_port(int'(x), int'(y))].push_back(pkt);
    n_sent++;
  endtask

  // Outputs are settled here and transfer at the next rising edge
  task automatic record_outputs();
    enoc_pkg::packet_t pkt;
    enoc_pkg::packet_t exp_pkt;
    int                src;
    int                idx;
    seen_val  = o_data_val;
    seen_data = o_data;
    for (int o = 0; o < PORTS; o++) begin
      if (o_data_val[o]) begin
        pkt = o_data[o];
        src = int'(pkt[SRC_LSB +: 3]);
        arrive_edge[o] = cyc + 1;
        n_received++;
        check_value("routing",
                    expected_port(int'(pkt[enoc_pkg::X_DEST_LSB +: enoc_pkg::COORD_W]),
                                  int'(pkt[enoc_pkg::Y_DEST_LSB +: enoc_pkg::COORD_W])),
                    o);
        idx = src * PORTS + o;
        if (src >= PORTS || sb_q[idx].size() == 0) begin
          $display("unexpected packet %0h on output %0d, nothing was sent that way", pkt, o);
          n_other_err++;
        end else begin
          exp_pkt = sb_q[idx].pop_front();       // Same pair must keep its order
          check_value("order", int'(exp_pkt), int'(pkt));
        end
      end
    end
  endtask

  task automatic cycle_begin();
    @(negedge clk);
    i_data_val = '0;                             // Offers last one cycle
  endtask

  task automatic cycle_end();
    #1;
    record_outputs();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending_packets() != 0 && n < DRAIN_CYCLES) begin
      cycle_begin();
      i_en = '1;
      cycle_end();
      n++;
    end
  endtask

  // Tests
  // --------------------
  task automatic check_reset_state();
    #1;
    check_value("reset_valid", 0, int'(o_data_val));
    check_value("reset_en", (1 << PORTS) - 1, int'(o_en));  // All queues empty
  endtask

  // One packet per input, each towards a different output
  task automatic measure_latency();
    int         out;
    int         write_edge;
    logic [3:0] c;
    for (int i = 0; i < PORTS; i++) begin
      out = (i + 2) % PORTS;
      c   = coords_for(out);
      arrive_edge[out] = -1;
      cycle_begin();
      write_edge = cyc + 1;
      offer(i, c[3:2], c[1:0]);
      cycle_end();
      cycle_begin();
      cycle_end();
      check_value("latency", 1, arrive_edge[out] - write_edge);
    end
  endtask

  // East input fills its queue towards a blocked west output
  task automatic block_one_output();
    int         src;
    int         out;
    logic [3:0] c;
    src = enoc_pkg::PORT_EAST;
    out = enoc_pkg::PORT_WEST;
    c   = coords_for(out);
    cycle_begin();
    i_en[out] = 1'b0;
    cycle_end();
    for (int n = 0; n < DEPTH; n++) begin
      cycle_begin();
      check_value("bp_en_open", 1, int'(o_en[src]));
      offer(src, c[3:2], c[1:0]);
      cycle_end();
    end
    cycle_begin();
    check_value("bp_en_full", 0, int'(o_en[src]));   // Queue holds DEPTH packets
    cycle_end();
    repeat (3) begin
      cycle_begin();
      cycle_end();
    end
    drain();                                     // Releases the output
  endtask

  // North and south compete for the core output
  task automatic alternate_grants();
    int         a;
    int         b;
    int         out;
    int         src;
    int         prev;
    int         got;
    logic [3:0] c;
    a   = enoc_pkg::PORT_NORTH;
    b   = enoc_pkg::PORT_SOUTH;
    out = enoc_pkg::PORT_CORE;
    c   = coords_for(out);
    cycle_begin();
    i_en[out] = 1'b0;                            // Let both queues fill first
    cycle_end();
    for (int n = 0; n < DEPTH; n++) begin
      cycle_begin();
      offer(a, c[3:2], c[1:0]);
      offer(b, c[3:2], c[1:0]);
      cycle_end();
    end
    prev = -1;
    got  = 0;
    while (got < 2 * DEPTH) begin
      cycle_begin();
      i_en = '1;
      cycle_end();
      if (seen_val[out]) begin
        src = int'(seen_data[out][SRC_LSB +: 3]);
        if (prev >= 0) check_value("fairness", (prev == a) ? b : a, src);
        prev = src;
        got++;
      end
    end
  endtask

  task automatic random_traffic();
    int          left [PORTS];
    int          remaining;
    logic [31:0] r;
    logic [31:0] d;
    for (int s = 0; s < PORTS; s++) left[s] = N_RAND;
    remaining = PORTS * N_RAND;
    while (remaining > 0) begin
      cycle_begin();
      r = next_random();
      for (int o = 0; o < PORTS; o++) begin
        i_en[o] = (r[2*o +: 2] != 2'b00);        // Each output open three cycles in four
      end
      r = next_random();
      for (int s = 0; s < PORTS; s++) begin
        if (left[s] > 0 && o_en[s] && r[s]) begin
          d = next_random();
          offer(s, d[1:0], d[3:2]);              // Any node in the 4x4 mesh
          left[s]--;
          remaining--;
        end
      end
      cycle_end();
    end
    drain();
  endtask

  // Main sequence
  // --------------------
  initial begin
    reset_n    = 1'b0;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    for (int s = 0; s < PORTS; s++) seq[s] = '0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;

    check_reset_state();
    measure_latency();
    block_one_output();
    alternate_grants();
    random_traffic();

    check_value("packet_count", n_sent, n_received);
    if (pending_packets() != 0) begin
      $display("%0d packets never left the router", pending_packets());
      n_other_err++;
    end

    $display("errors: %0d wrong values, %0d other failures", n_value_err, n_other_err);
    if (n_value_err + n_other_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Hang guard
  initial begin
    while (cyc < CYCLE_LIMIT) @(posedge clk);
    $display("timeout after %0d cycles, traffic did not drain", cyc);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
